// File: Bender.yml
package:
  name: bpf_filter

sources:
  - common/bpf_pkg.sv
  - datapath/bpf_alu.sv
  - datapath/bpf_datapath.sv
  - hw/bpf_alu_timer.sv
  - hw/bpf_ctrl.sv
  - hw/bpf_mem.sv
  - hw/bpf_filter_top.sv
  - target: test
    files:
      - testbench/tb_clock.sv
      - testbench/bpf_filter_tb.sv

// File: common/bpf_pkg.sv
package bpf_pkg;

    localparam int insn_depth     = 64;   // Program words
    localparam int insn_addr_w    = 6;    // PC width
    localparam int pkt_depth      = 256;  // Packet bytes
    localparam int pkt_addr_w     = 8;
    localparam int scratch_depth  = 16;   // BPF M[] words
    localparam int scratch_addr_w = 4;
    localparam int long_op_cycles = 31;   // Timer load for slow ALU ops

    // Opcode fields, encodings as in classic BPF
    typedef enum logic [2:0] {
        BPF_LD, BPF_LDX, BPF_ST, BPF_STX, BPF_ALU, BPF_JMP, BPF_RET, BPF_MISC
    } bpf_class_e;

    typedef enum logic [2:0] {
        MODE_IMM, MODE_ABS, MODE_IND, MODE_MEM, MODE_LEN, MODE_MSH
    } bpf_mode_e;

    typedef enum logic [1:0] {SIZE_W, SIZE_H, SIZE_B} bpf_size_e;

    typedef enum logic [3:0] {
        ALU_ADD = 4'h0, ALU_SUB = 4'h1, ALU_MUL = 4'h2, ALU_DIV = 4'h3,
        ALU_OR  = 4'h4, ALU_AND = 4'h5, ALU_LSH = 4'h6, ALU_RSH = 4'h7,
        ALU_NEG = 4'h8, ALU_MOD = 4'h9, ALU_XOR = 4'ha
    } bpf_alu_op_e;

    typedef enum logic [2:0] {JMP_JA, JMP_JEQ, JMP_JGT, JMP_JGE, JMP_JSET} bpf_jmp_e;

    typedef enum logic [1:0] {RET_K, RET_X, RET_A} bpf_ret_e;

    // Register input muxes
    typedef enum logic [2:0] {
        A_SEL_IMM, A_SEL_PKT, A_SEL_MEM, A_SEL_LEN, A_SEL_ALU, A_SEL_X
    } bpf_a_sel_e;

    typedef enum logic [2:0] {
        X_SEL_IMM, X_SEL_PKT, X_SEL_MEM, X_SEL_LEN, X_SEL_MSH, X_SEL_A
    } bpf_x_sel_e;

    typedef enum logic [1:0] {PC_PLUS_1, PC_PLUS_JT, PC_PLUS_JF, PC_PLUS_K} bpf_pc_sel_e;

    typedef enum logic [2:0] {
        ST_IDLE, ST_FETCH, ST_DECODE, ST_WRITE_A, ST_WRITE_X, ST_ALU_WAIT
    } bpf_state_e;

    typedef struct packed {
        logic [15:0] opcode;
        logic [7:0]  jt;     // Offset if condition true
        logic [7:0]  jf;     // Offset if condition false
        logic [31:0] k;      // Immediate
    } bpf_insn_t;

    // Controller to datapath and memories
    typedef struct packed {
        bpf_a_sel_e  a_sel;
        bpf_x_sel_e  x_sel;
        bpf_pc_sel_e pc_sel;
        logic        pc_en;
        logic        pc_clr;
        logic        a_en;
        logic        x_en;
        bpf_alu_op_e alu_op;
        logic        alu_use_x;     // Operand B is X, else k
        logic        addr_ind;      // Packet address X+k, else k
        bpf_size_e   xfer_size;
        logic        pkt_rd_en;
        logic        insn_rd_en;
        logic        scratch_wr_en;
        logic        scratch_src_x; // Store X, else A
    } bpf_ctrl_t;

    // Datapath status back to the controller
    typedef struct packed {
        logic eq;
        logic gt;
        logic ge;
        logic set;
        logic a_zero;
        logic x_zero;
        logic k_zero;
    } bpf_flags_t;

endpackage

// File: datapath/bpf_alu.sv
`timescale 1ns/10ps

module bpf_alu (
    input  bpf_pkg::bpf_alu_op_e op,
    input  logic [31:0]          a,
    input  logic [31:0]          b,
    output logic [31:0]          result
);

    logic [4:0] shamt;
    logic       b_zero;

    assign shamt  = b[4:0];       // Shift count modulo 32
    assign b_zero = (b == '0);

    always_comb begin
        case (op)
            bpf_pkg::ALU_ADD: result = a + b;
            bpf_pkg::ALU_SUB: result = a - b;
            bpf_pkg::ALU_MUL: result = a * b;                 // Low 32 bits kept
            bpf_pkg::ALU_DIV: result = b_zero ? '0 : a / b;   // x/0 gives 0
            bpf_pkg::ALU_OR:  result = a | b;
            bpf_pkg::ALU_AND: result = a & b;
            bpf_pkg::ALU_LSH: result = a << shamt;
            bpf_pkg::ALU_RSH: result = a >> shamt;            // Logical shift
            bpf_pkg::ALU_NEG: result = -a;                    // b unused
            bpf_pkg::ALU_MOD: result = b_zero ? '0 : a % b;
            bpf_pkg::ALU_XOR: result = a ^ b;
            default:          result = a;                     // Undefined ops leave A as is
        endcase
    end

endmodule

// File: datapath/bpf_datapath.sv
`timescale 1ns/10ps

module bpf_datapath (
    input  logic                                clk,
    input  logic                                reset,
    input  bpf_pkg::bpf_ctrl_t                  ctrl,
    input  bpf_pkg::bpf_insn_t                  insn,
    input  logic [31:0]                         pkt_word,
    input  logic [7:0]                          msh_byte,
    input  logic [31:0]                         pkt_len,
    output logic [bpf_pkg::insn_addr_w-1:0]     pc,
    output logic [bpf_pkg::pkt_addr_w-1:0]      pkt_addr,
    output bpf_pkg::bpf_flags_t                 flags
);

    logic [31:0] a_reg;
    logic [31:0] x_reg;
    logic [31:0] scratch [bpf_pkg::scratch_depth];
    logic [bpf_pkg::scratch_addr_w-1:0] scratch_addr;
    logic [31:0] scratch_rd;
    logic [31:0] alu_b;
    logic [31:0] alu_result;
    logic [31:0] msh_val;
    logic [31:0] a_next;
    logic [31:0] x_next;

    assign scratch_addr = insn.k[bpf_pkg::scratch_addr_w-1:0];
    assign scratch_rd   = scratch[scratch_addr];                    // Asynchronous read
    assign alu_b        = ctrl.alu_use_x ? x_reg : insn.k;
    assign msh_val      = {26'd0, msh_byte[3:0], 2'b00};            // 4 * (P[k] & 0xf)

    // Byte address wraps modulo 256
    assign pkt_addr = ctrl.addr_ind ? x_reg[7:0] + insn.k[7:0] : insn.k[7:0];

    bpf_alu bpf_alu_i (
        .op     (ctrl.alu_op),
        .a      (a_reg),
        .b      (alu_b),
        .result (alu_result)
    );

    always_comb begin
        case (ctrl.a_sel)
            bpf_pkg::A_SEL_IMM: a_next = insn.k;
            bpf_pkg::A_SEL_PKT: a_next = pkt_word;
            bpf_pkg::A_SEL_MEM: a_next = scratch_rd;
            bpf_pkg::A_SEL_LEN: a_next = pkt_len;
            bpf_pkg::A_SEL_ALU: a_next = alu_result;
            default:            a_next = x_reg;      // TXA
        endcase
        case (ctrl.x_sel)
            bpf_pkg::X_SEL_IMM: x_next = insn.k;
            bpf_pkg::X_SEL_PKT: x_next = pkt_word;
            bpf_pkg::X_SEL_MEM: x_next = scratch_rd;
            bpf_pkg::X_SEL_LEN: x_next = pkt_len;
            bpf_pkg::X_SEL_MSH: x_next = msh_val;
            default:            x_next = a_reg;      // TAX
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            a_reg <= '0;
            x_reg <= '0;
            pc    <= '0;
            for (int i = 0; i < bpf_pkg::scratch_depth; i++) scratch[i] <= '0;
        end else begin
            if (ctrl.a_en) a_reg <= a_next;
            if (ctrl.x_en) x_reg <= x_next;
            if (ctrl.scratch_wr_en) scratch[scratch_addr] <= ctrl.scratch_src_x ? x_reg : a_reg;
            if (ctrl.pc_clr) begin
                pc <= '0;
            end else if (ctrl.pc_en) begin
                case (ctrl.pc_sel)
                    bpf_pkg::PC_PLUS_1:  pc <= pc + 1'b1;
                    bpf_pkg::PC_PLUS_JT: pc <= pc + insn.jt[bpf_pkg::insn_addr_w-1:0];
                    bpf_pkg::PC_PLUS_JF: pc <= pc + insn.jf[bpf_pkg::insn_addr_w-1:0];
                    default:             pc <= pc + insn.k[bpf_pkg::insn_addr_w-1:0];
                endcase
            end
        end
    end

    // Compare A with X or k
    assign flags.eq     = (a_reg == alu_b);
    assign flags.gt     = (a_reg > alu_b);
    assign flags.ge     = (a_reg >= alu_b);
    assign flags.set    = |(a_reg & alu_b);
    assign flags.a_zero = (a_reg == '0);
    assign flags.x_zero = (x_reg == '0);
    assign flags.k_zero = (insn.k == '0);

endmodule

// File: hw/bpf_alu_timer.sv
`timescale 1ns/10ps

module bpf_alu_timer (
    input  logic clk,
    input  logic reset,
    input  logic load,
    output logic done
);

    logic [4:0] count;
    logic       running;

    always_ff @(posedge clk) begin
        if (reset) begin
            count   <= '0;
            running <= 1'b0;
        end else if (load) begin
            count   <= 5'(bpf_pkg::long_op_cycles);
            running <= 1'b1;
        end else if (running) begin
            count   <= count - 5'd1;
            running <= (count != 5'd0); // Stop after the zero cycle
        end
    end

    assign done = running && (count == 5'd0); // One cycle wide

endmodule

// File: hw/bpf_ctrl.sv
`timescale 1ns/10ps

module bpf_ctrl (
    input  logic                clk,
    input  logic                reset,
    input  logic                start,
    input  logic [15:0]         opcode,
    input  bpf_pkg::bpf_flags_t flags,
    input  logic                timer_done,
    output logic                timer_load,
    output bpf_pkg::bpf_ctrl_t  ctrl,
    output logic                busy,
    output logic                accept,
    output logic                reject
);

    bpf_pkg::bpf_state_e state;
    bpf_pkg::bpf_state_e next_state;
    bpf_pkg::bpf_class_e op_class;
    bpf_pkg::bpf_mode_e  mode;
    bpf_pkg::bpf_jmp_e   jmp;
    bpf_pkg::bpf_ret_e   ret_src;
    logic                jump_taken;
    logic                ret_nonzero;
    logic                accept_nxt;
    logic                reject_nxt;

    assign op_class = bpf_pkg::bpf_class_e'(opcode[2:0]);
    assign mode     = bpf_pkg::bpf_mode_e'(opcode[7:5]);
    assign jmp      = bpf_pkg::bpf_jmp_e'(opcode[6:4]);
    assign ret_src  = bpf_pkg::bpf_ret_e'(opcode[4:3]);

    always_comb begin
        case (jmp)
            bpf_pkg::JMP_JEQ:  jump_taken = flags.eq;
            bpf_pkg::JMP_JGT:  jump_taken = flags.gt;
            bpf_pkg::JMP_JGE:  jump_taken = flags.ge;
            bpf_pkg::JMP_JSET: jump_taken = flags.set;
            default:           jump_taken = 1'b0;
        endcase
        case (ret_src)
            bpf_pkg::RET_K: ret_nonzero = !flags.k_zero;
            bpf_pkg::RET_X: ret_nonzero = !flags.x_zero;
            default:        ret_nonzero = !flags.a_zero; // Code 3 treated as A
        endcase
    end

    always_comb begin
        ctrl = '0;                                   // Enables low unless raised below
        ctrl.alu_op    = bpf_pkg::bpf_alu_op_e'(opcode[7:4]);
        ctrl.alu_use_x = opcode[3];                  // Same bit for ALU and jumps
        ctrl.addr_ind  = (mode == bpf_pkg::MODE_IND);
        ctrl.xfer_size = bpf_pkg::bpf_size_e'(opcode[4:3]);
        timer_load = 1'b0;
        accept_nxt = 1'b0;
        reject_nxt = 1'b0;
        next_state = state;
        case (state)
            bpf_pkg::ST_IDLE: begin
                ctrl.pc_clr = 1'b1;
                if (start) next_state = bpf_pkg::ST_FETCH;
            end
            bpf_pkg::ST_FETCH: begin
                ctrl.insn_rd_en = 1'b1;              // insn valid next cycle
                ctrl.pc_en      = 1'b1;              // PC_PLUS_1 by default
                next_state      = bpf_pkg::ST_DECODE;
            end
            bpf_pkg::ST_DECODE: begin
                next_state = bpf_pkg::ST_FETCH;      // Most classes finish here
                case (op_class)
                    bpf_pkg::BPF_LD: begin
                        case (mode)
                            bpf_pkg::MODE_IMM: ctrl.a_sel = bpf_pkg::A_SEL_IMM;
                            bpf_pkg::MODE_MEM: ctrl.a_sel = bpf_pkg::A_SEL_MEM;
                            bpf_pkg::MODE_LEN: ctrl.a_sel = bpf_pkg::A_SEL_LEN;
                            default: ;
                        endcase
                        ctrl.a_en = mode inside {bpf_pkg::MODE_IMM, bpf_pkg::MODE_MEM,
                                                 bpf_pkg::MODE_LEN};
                        if (mode inside {bpf_pkg::MODE_ABS, bpf_pkg::MODE_IND}) begin
                            ctrl.pkt_rd_en = 1'b1;   // Synchronous RAM read
                            next_state     = bpf_pkg::ST_WRITE_A;
                        end
                    end
                    bpf_pkg::BPF_LDX: begin
                        case (mode)
                            bpf_pkg::MODE_IMM: ctrl.x_sel = bpf_pkg::X_SEL_IMM;
                            bpf_pkg::MODE_MEM: ctrl.x_sel = bpf_pkg::X_SEL_MEM;
                            bpf_pkg::MODE_LEN: ctrl.x_sel = bpf_pkg::X_SEL_LEN;
                            bpf_pkg::MODE_MSH: ctrl.x_sel = bpf_pkg::X_SEL_MSH;
                            default: ;
                        endcase
                        ctrl.x_en = mode inside {bpf_pkg::MODE_IMM, bpf_pkg::MODE_MEM,
                                                 bpf_pkg::MODE_LEN, bpf_pkg::MODE_MSH};
                        if (mode inside {bpf_pkg::MODE_ABS, bpf_pkg::MODE_IND}) begin
                            ctrl.pkt_rd_en = 1'b1;
                            next_state     = bpf_pkg::ST_WRITE_X;
                        end
                    end
                    bpf_pkg::BPF_ST:  ctrl.scratch_wr_en = 1'b1;
                    bpf_pkg::BPF_STX: begin
                        ctrl.scratch_wr_en = 1'b1;
                        ctrl.scratch_src_x = 1'b1;
                    end
                    bpf_pkg::BPF_ALU: begin
                        case (ctrl.alu_op)
                            bpf_pkg::ALU_ADD, bpf_pkg::ALU_SUB, bpf_pkg::ALU_OR,
                            bpf_pkg::ALU_AND, bpf_pkg::ALU_XOR:
                                next_state = bpf_pkg::ST_WRITE_A;
                            bpf_pkg::ALU_MUL, bpf_pkg::ALU_DIV, bpf_pkg::ALU_MOD,
                            bpf_pkg::ALU_LSH, bpf_pkg::ALU_RSH, bpf_pkg::ALU_NEG: begin
                                timer_load = 1'b1;   // 32 cycle wait
                                next_state = bpf_pkg::ST_ALU_WAIT;
                            end
                            default: ;               // Undefined op skipped
                        endcase
                    end
                    bpf_pkg::BPF_JMP: begin
                        ctrl.pc_en = 1'b1;           // Offset relative to PC+1
                        if (jmp == bpf_pkg::JMP_JA) ctrl.pc_sel = bpf_pkg::PC_PLUS_K;
                        else if (jump_taken)        ctrl.pc_sel = bpf_pkg::PC_PLUS_JT;
                        else                        ctrl.pc_sel = bpf_pkg::PC_PLUS_JF;
                    end
                    bpf_pkg::BPF_RET: begin
                        accept_nxt = ret_nonzero;
                        reject_nxt = !ret_nonzero;
                        next_state = bpf_pkg::ST_IDLE;
                    end
                    default: begin                   // MISC
                        if (opcode[7:3] == 5'd0) begin
                            ctrl.x_sel = bpf_pkg::X_SEL_A;  // TAX
                            ctrl.x_en  = 1'b1;
                        end else begin
                            ctrl.a_sel = bpf_pkg::A_SEL_X;  // TXA
                            ctrl.a_en  = 1'b1;
                        end
                    end
                endcase
            end
            bpf_pkg::ST_WRITE_A: begin
                // Shared by packet loads and ALU results
                ctrl.a_sel = (op_class == bpf_pkg::BPF_ALU) ? bpf_pkg::A_SEL_ALU
                                                              : bpf_pkg::A_SEL_PKT;
                ctrl.a_en  = 1'b1;
                next_state = bpf_pkg::ST_FETCH;
            end
            bpf_pkg::ST_WRITE_X: begin
                ctrl.x_sel = bpf_pkg::X_SEL_PKT;
                ctrl.x_en  = 1'b1;
                next_state = bpf_pkg::ST_FETCH;
            end
            bpf_pkg::ST_ALU_WAIT: if (timer_done) next_state = bpf_pkg::ST_WRITE_A;
            default: next_state = bpf_pkg::ST_IDLE;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state  <= bpf_pkg::ST_IDLE;
            accept <= 1'b0;
            reject <= 1'b0;
        end else begin
            state  <= next_state;
            accept <= accept_nxt;  // Pulse lands in the IDLE cycle
            reject <= reject_nxt;
        end
    end

    assign busy = (state != bpf_pkg::ST_IDLE);  // Low together with the verdict pulse

endmodule

// File: hw/bpf_filter_top.sv
`timescale 1ns/10ps

module bpf_filter_top (
    input  logic                            clk,
    input  logic                            reset,
    input  logic                            start,
    input  logic [31:0]                     pkt_len,
    input  logic                            prog_wr_en,
    input  logic [bpf_pkg::insn_addr_w-1:0] prog_addr,
    input  bpf_pkg::bpf_insn_t              prog_data,
    input  logic                            pkt_wr_en,
    input  logic [bpf_pkg::pkt_addr_w-1:0]  pkt_addr,
    input  logic [7:0]                      pkt_data,
    output logic                            busy,
    output logic                            accept,
    output logic                            reject
);

    bpf_pkg::bpf_ctrl_t  ctrl;
    bpf_pkg::bpf_flags_t flags;
    bpf_pkg::bpf_insn_t  insn;
    logic                timer_load;
    logic                timer_done;
    logic [bpf_pkg::insn_addr_w-1:0] pc;
    logic [bpf_pkg::pkt_addr_w-1:0]  rd_addr;  // Packet read address from datapath
    logic [31:0]         pkt_word;
    logic [7:0]          msh_byte;

    bpf_ctrl bpf_ctrl_i (
        .clk        (clk),
        .reset      (reset),
        .start      (start),
        .opcode     (insn.opcode),
        .flags      (flags),
        .timer_done (timer_done),
        .timer_load (timer_load),
        .ctrl       (ctrl),
        .busy       (busy),
        .accept     (accept),
        .reject     (reject)
    );

    bpf_alu_timer bpf_alu_timer_i (
        .clk   (clk),
        .reset (reset),
        .load  (timer_load),
        .done  (timer_done)
    );

    bpf_datapath bpf_datapath_i (
        .clk      (clk),
        .reset    (reset),
        .ctrl     (ctrl),
        .insn     (insn),
        .pkt_word (pkt_word),
        .msh_byte (msh_byte),
        .pkt_len  (pkt_len),
        .pc       (pc),
        .pkt_addr (rd_addr),
        .flags    (flags)
    );

    bpf_mem bpf_mem_i (
        .clk         (clk),
        .prog_wr_en  (prog_wr_en),
        .prog_addr   (prog_addr),
        .prog_data   (prog_data),
        .pkt_wr_en   (pkt_wr_en),
        .pkt_addr_wr (pkt_addr),
        .pkt_data    (pkt_data),
        .insn_rd_en  (ctrl.insn_rd_en),
        .pc          (pc),
        .pkt_rd_en   (ctrl.pkt_rd_en),
        .pkt_addr    (rd_addr),
        .xfer_size   (ctrl.xfer_size),
        .insn        (insn),
        .pkt_word    (pkt_word),
        .msh_byte    (msh_byte)
    );

endmodule

// File: hw/bpf_mem.sv
`timescale 1ns/10ps

module bpf_mem (
    input  logic                            clk,
    input  logic                            prog_wr_en,
    input  logic [bpf_pkg::insn_addr_w-1:0] prog_addr,
    input  bpf_pkg::bpf_insn_t              prog_data,
    input  logic                            pkt_wr_en,
    input  logic [bpf_pkg::pkt_addr_w-1:0]  pkt_addr_wr,
    input  logic [7:0]                      pkt_data,
    input  logic                            insn_rd_en,
    input  logic [bpf_pkg::insn_addr_w-1:0] pc,
    input  logic                            pkt_rd_en,
    input  logic [bpf_pkg::pkt_addr_w-1:0]  pkt_addr,
    input  bpf_pkg::bpf_size_e              xfer_size,
    output bpf_pkg::bpf_insn_t              insn,
    output logic [31:0]                     pkt_word,
    output logic [7:0]                      msh_byte
);

    bpf_pkg::bpf_insn_t insn_ram [bpf_pkg::insn_depth];
    logic [7:0]         pkt_ram  [bpf_pkg::pkt_depth];
    logic [bpf_pkg::pkt_addr_w-1:0] addr1;
    logic [bpf_pkg::pkt_addr_w-1:0] addr2;
    logic [bpf_pkg::pkt_addr_w-1:0] addr3;
    logic [31:0]        gathered;

    // Consecutive byte addresses, wrapping at 256
    assign addr1 = pkt_addr + 1'b1;
    assign addr2 = pkt_addr + 2'd2;
    assign addr3 = pkt_addr + 2'd3;

    always_comb begin
        case (xfer_size)
            bpf_pkg::SIZE_W: gathered = {pkt_ram[pkt_addr], pkt_ram[addr1],
                                         pkt_ram[addr2], pkt_ram[addr3]};  // Big-endian
            bpf_pkg::SIZE_H: gathered = {16'd0, pkt_ram[pkt_addr], pkt_ram[addr1]};
            default:         gathered = {24'd0, pkt_ram[pkt_addr]};
        endcase
    end

    assign msh_byte = pkt_ram[pkt_addr]; // Address is k during MSH

    always_ff @(posedge clk) begin
        if (prog_wr_en) insn_ram[prog_addr] <= prog_data;
        if (insn_rd_en) insn <= insn_ram[pc];
    end

    always_ff @(posedge clk) begin
        if (pkt_wr_en) pkt_ram[pkt_addr_wr] <= pkt_data;
        if (pkt_rd_en) pkt_word <= gathered;  // Held through WRITE_A/WRITE_X
    end

endmodule

// File: sim.f
common/bpf_pkg.sv
datapath/bpf_alu.sv
datapath/bpf_datapath.sv
hw/bpf_alu_timer.sv
hw/bpf_ctrl.sv
hw/bpf_mem.sv
hw/bpf_filter_top.sv
testbench/tb_clock.sv
testbench/bpf_filter_tb.sv

// File: testbench/bpf_filter_tb.sv
`timescale 1ns/10ps

module bpf_filter_tb;

    localparam int n_rows       = 16;
    localparam int n_code       = 105;             // Sum of program lengths
    localparam int max_cycles   = n_rows * 500;    // Watchdog limit
    localparam int kind_fixed   = 0;
    localparam int kind_rand_gt = 1;               // Accept if P[3] > 0x7f
    localparam int kind_rand_ge = 2;               // Accept if P[9] >= P[2]
    localparam logic [127:0] std_pkt    = 128'h4500_1234_a55a_0ff0_0806_c381_7e00_ff10;
    localparam logic [63:0]  ret_reject = 64'h0006_00_00_00000000;  // Filler word RET #0

    logic                            clk;
    logic                            reset;
    logic                            start;
    logic [31:0]                     pkt_len;
    logic                            prog_wr_en;
    logic [bpf_pkg::insn_addr_w-1:0] prog_addr;
    bpf_pkg::bpf_insn_t              prog_data;
    logic                            pkt_wr_en;
    logic [bpf_pkg::pkt_addr_w-1:0]  pkt_addr;
    logic [7:0]                      pkt_data;
    logic                            busy;
    logic                            accept;
    logic                            reject;

    string        name_tbl    [n_rows];
    int           ninsn_tbl   [n_rows];
    logic [127:0] pkt_tbl     [n_rows];   // Byte 0 in the top bits
    logic [31:0]  len_tbl     [n_rows];
    logic         verdict_tbl [n_rows];   // 1 for accept
    int           kind_tbl    [n_rows];
    logic         slow_tbl    [n_rows];   // Program holds a slow ALU op
    int           row_count   = 0;

    // Programs back to back with fields opcode_jt_jf_k
    logic [63:0] code [n_code] = '{
        64'h0020_00_00_00000002, 64'h0015_00_01_1234a55a, 64'h0006_00_00_00000001, // ld_w_abs
        64'h0006_00_00_00000000,
        64'h0001_00_00_00000005, 64'h0048_00_00_00000003, 64'h0015_00_01_00000806, // ld_h_ind
        64'h0006_00_00_00000001, 64'h0006_00_00_00000000,
        64'h0001_00_00_0000000a, 64'h0050_00_00_00000004, 64'h0015_00_01_000000fe, // ld_b_ind
        64'h0006_00_00_00000001, 64'h0006_00_00_00000000,
        64'h0029_00_00_00000006, 64'h0087_00_00_00000000, 64'h0015_00_01_00000ff0, // ldx_h_abs
        64'h0006_00_00_00000001, 64'h0006_00_00_00000000,
        64'h0000_00_00_00000010, 64'h0004_00_00_00000005, 64'h0014_00_00_00000015, // fast K
        64'h0044_00_00_00000030, 64'h0054_00_00_0000000f, 64'h00a4_00_00_00000005,
        64'h0016_00_00_00000000,
        64'h0001_00_00_0000ff00, 64'h0000_00_00_00001234, 64'h005c_00_00_00000000, // fast X
        64'h00ac_00_00_00000000, 64'h000c_00_00_00000000, 64'h001c_00_00_00000000,
        64'h004c_00_00_00000000, 64'h001c_00_00_00000000, 64'h0016_00_00_00000000,
        64'h0000_00_00_00000007, 64'h0024_00_00_00000006, 64'h0034_00_00_00000004, // slow K
        64'h0094_00_00_00000004, 64'h0064_00_00_00000024, 64'h0074_00_00_00000003,
        64'h0084_00_00_00000000, 64'h0015_00_01_fffffffc, 64'h0006_00_00_00000001,
        64'h0006_00_00_00000000,
        64'h0001_00_00_00000000, 64'h0000_00_00_00000063, 64'h003c_00_00_00000000, // 99/0
        64'h0016_00_00_00000000,
        64'h0000_00_00_00000063, 64'h0094_00_00_00000000, 64'h0016_00_00_00000000, // 99%0
        64'h0000_00_00_0000abcd, 64'h0002_00_00_00000003, 64'h0001_00_00_00001111, // M[]
        64'h0003_00_00_00000009, 64'h0000_00_00_00000000, 64'h0001_00_00_00000000,
        64'h0060_00_00_00000003, 64'h0061_00_00_00000009, 64'h000c_00_00_00000000,
        64'h0015_00_01_0000bcde, 64'h0006_00_00_00000001, 64'h0006_00_00_00000000,
        64'h0080_00_00_00000000, 64'h00b1_00_00_00000006, 64'h000c_00_00_00000000, // len
        64'h0007_00_00_00000000, 64'h0080_00_00_00000000, 64'h000c_00_00_00000000,
        64'h0081_00_00_00000000, 64'h001c_00_00_00000000, 64'h0015_00_01_0000007c,
        64'h0006_00_00_00000001, 64'h0006_00_00_00000000,
        64'h0000_00_00_0000000a, 64'h0025_01_00_0000000a, 64'h0035_01_00_0000000a, // jgt/jge
        64'h0006_00_00_00000000, 64'h0025_01_00_00000009, 64'h0006_00_00_00000000,
        64'h0035_01_00_0000000b, 64'h0006_00_00_00000005, 64'h0006_00_00_00000000,
        64'h0000_00_00_0000000c, 64'h0045_01_00_00000003, 64'h0045_01_00_00000004, // jset/ja
        64'h0006_00_00_00000000, 64'h0005_00_00_00000001, 64'h0006_00_00_00000000,
        64'h0006_00_00_00000001,
        64'h0001_00_00_00000077, 64'h0000_00_00_00000077, 64'h001d_01_00_00000000, // ret X
        64'h0006_00_00_00000000, 64'h000e_00_00_00000000,
        64'h0030_00_00_00000003, 64'h0025_00_01_0000007f, 64'h0006_00_00_00000001, // rand gt
        64'h0006_00_00_00000000,
        64'h0031_00_00_00000002, 64'h0030_00_00_00000009, 64'h003d_00_01_00000000, // rand ge
        64'h0006_00_00_00000001, 64'h0006_00_00_00000000
    };

    logic [7:0]  pkt_bytes [16];
    logic [31:0] lfsr_state  = 32'hdc40b5f9;
    int          error_count = 0;
    int          cycle_count = 0;

    tb_clock tb_clock_i (
        .clk   (clk),
        .reset (reset)
    );

    bpf_filter_top bpf_filter_top_i (
        .clk        (clk),
        .reset      (reset),
        .start      (start),
        .pkt_len    (pkt_len),
        .prog_wr_en (prog_wr_en),
        .prog_addr  (prog_addr),
        .prog_data  (prog_data),
        .pkt_wr_en  (pkt_wr_en),
        .pkt_addr   (pkt_addr),
        .pkt_data   (pkt_data),
        .busy       (busy),
        .accept     (accept),
        .reject     (reject)
    );

    // Galois LFSR with polynomial x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        if (s[0]) return (s >> 1) ^ 32'h80200003;
        return s >> 1;
    endfunction

    function automatic string verdict_name(input logic v);
        if (v === 1'b1) return "accept";
        if (v === 1'b0) return "reject";
        return "no verdict";
    endfunction

    task automatic random_byte(output logic [7:0] b);
        for (int i = 0; i < 8; i++) begin
            b          = {b[6:0], lfsr_state[0]};  // One step per bit taken
            lfsr_state = lfsr_step(lfsr_state);
        end
    endtask

    // Inputs applied 1 ns after the edge where outputs have settled
    task automatic step();
        @(posedge clk);
        #1;
    endtask

    task automatic add_row(input string name, input int n, input logic [127:0] pkt,
                           input logic [31:0] len, input logic verdict, input int kind,
                           input logic slow);
        name_tbl[row_count]    = name;
        ninsn_tbl[row_count]   = n;
        pkt_tbl[row_count]     = pkt;
        len_tbl[row_count]     = len;
        verdict_tbl[row_count] = verdict;
        kind_tbl[row_count]    = kind;
        slow_tbl[row_count]    = slow;
        row_count++;
    endtask

    // 12 program words and 16 packet bytes written side by side
    task automatic load_row(input int row, input int offset);
        for (int i = 0; i < 16; i++) begin
            prog_wr_en = (i < 12);
            prog_addr  = 6'(i);
            prog_data  = (i < ninsn_tbl[row]) ? code[offset + i] : ret_reject;
            pkt_wr_en  = 1'b1;
            pkt_addr   = 8'(i);
            pkt_data   = pkt_bytes[i];
            step();
        end
        prog_wr_en = 1'b0;
        pkt_wr_en  = 1'b0;
    endtask

    task automatic run_row(input int row, input logic expected);
        int   run_cycles;
        int   busy_cycles;
        logic verdict;
        run_cycles  = 0;
        busy_cycles = 0;
        start = 1'b1;
        step();
        start = 1'b0;
        while (!(accept || reject)) begin
            if (busy) busy_cycles++;
            start = (run_cycles == 2) && busy;  // Extra start while busy is ignored
            step();
            run_cycles++;
        end
        start   = 1'b0;
        verdict = accept;
        if (accept && reject) begin
            $display("Accept and reject pulsed together in %s", name_tbl[row]);
            error_count++;
        end
        if (verdict !== expected) begin
            $display("Mismatch in %s: expected %s, actual %s", name_tbl[row],
                     verdict_name(expected), verdict_name(verdict));
            error_count++;
        end
        if (busy !== 1'b0) begin
            $display("Busy still high in the verdict cycle of %s", name_tbl[row]);
            error_count++;
        end
        if (busy_cycles != run_cycles) begin
            $display("Busy dropped before the verdict in %s", name_tbl[row]);
            error_count++;
        end
        if (slow_tbl[row] && busy_cycles < 32) begin
            $display("Busy high for only %0d cycles in slow run %s", busy_cycles,
                     name_tbl[row]);
            error_count++;
        end
        repeat (3) begin
            step();
            if (accept !== 1'b0 || reject !== 1'b0 || busy !== 1'b0) begin
                $display("Second pulse or busy again after the verdict in %s", name_tbl[row]);
                error_count++;
            end
        end
    endtask

    always @(posedge clk) begin
        cycle_count = cycle_count + 1;
        if (cycle_count >= max_cycles) begin
            $display("Timeout: runs did not finish within %0d cycles", max_cycles);
            $display("Test failures found");
            $finish;
        end
    end

    initial begin
        int   offset;
        logic expected;
        start      = 1'b0;
        pkt_len    = '0;
        prog_wr_en = 1'b0;
        prog_addr  = '0;
        prog_data  = '0;
        pkt_wr_en  = 1'b0;
        pkt_addr   = '0;
        pkt_data   = '0;
        offset     = 0;

        //       name            n  packet   pkt_len  verdict kind          slow
        add_row("ld_w_abs",      4, std_pkt, 32'd16,  1'b1,   kind_fixed,   1'b0);
        add_row("ld_h_ind",      5, std_pkt, 32'd16,  1'b1,   kind_fixed,   1'b0);
        add_row("ld_b_ind_miss", 5, std_pkt, 32'd16,  1'b0,   kind_fixed,   1'b0);
        add_row("ldx_h_abs_txa", 5, std_pkt, 32'd16,  1'b1,   kind_fixed,   1'b0);
        add_row("alu_fast_k",    7, std_pkt, 32'd16,  1'b1,   kind_fixed,   1'b0);
        add_row("alu_fast_x",    9, std_pkt, 32'd16,  1'b0,   kind_fixed,   1'b0);
        add_row("alu_slow_k",   10, std_pkt, 32'd16,  1'b1,   kind_fixed,   1'b1);
        add_row("div_by_zero",   4, std_pkt, 32'd16,  1'b0,   kind_fixed,   1'b1);
        add_row("mod_by_zero",   3, std_pkt, 32'd16,  1'b0,   kind_fixed,   1'b1);
        add_row("scratch_mem",  12, std_pkt, 32'd16,  1'b1,   kind_fixed,   1'b0);
        add_row("len_msh_tax",  11, std_pkt, 32'h40,  1'b1,   kind_fixed,   1'b0);
        add_row("jgt_jge",       9, std_pkt, 32'd16,  1'b1,   kind_fixed,   1'b0);
        add_row("jset_ja",       7, std_pkt, 32'd16,  1'b1,   kind_fixed,   1'b0);
        add_row("jeq_x_ret_x",   5, std_pkt, 32'd16,  1'b1,   kind_fixed,   1'b0);
        add_row("rand_byte_gt",  4, std_pkt, 32'd16,  1'b0,   kind_rand_gt, 1'b0);
        add_row("rand_byte_ge",  5, std_pkt, 32'd16,  1'b0,   kind_rand_ge, 1'b0);

        wait (reset === 1'b0);          // Released 1 ns after an edge
        if (busy !== 1'b0 || accept !== 1'b0 || reject !== 1'b0) begin
            $display("Outputs not idle after reset: busy=%b accept=%b reject=%b",
                     busy, accept, reject);
            error_count++;
        end

        for (int r = 0; r < row_count; r++) begin
            for (int i = 0; i < 16; i++) begin
                if (kind_tbl[r] == kind_fixed) pkt_bytes[i] = pkt_tbl[r][127 - 8*i -: 8];
                else random_byte(pkt_bytes[i]);
            end
            case (kind_tbl[r])          // Random rows derive the verdict from their bytes
                kind_rand_gt: expected = (pkt_bytes[3] > 8'h7f);
                kind_rand_ge: expected = (pkt_bytes[9] >= pkt_bytes[2]);
                default:      expected = verdict_tbl[r];
            endcase
            pkt_len = len_tbl[r];       // Held for the whole run
            load_row(r, offset);
            run_row(r, expected);
            offset += ninsn_tbl[r];
        end

        $display("Rows run: %0d, errors: %0d", row_count, error_count);
        if (error_count == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

endmodule

// File: testbench/tb_clock.sv
`timescale 1ns/10ps

module tb_clock (
    output logic clk,
    output logic reset
);

    localparam int half_period  = 5;   // 10 ns clock
    localparam int reset_cycles = 10;

    initial begin
        clk = 1'b0;
        forever #half_period clk = ~clk;
    end

    initial begin
        reset = 1'b1;
        repeat (reset_cycles) @(posedge clk);
        #1 reset = 1'b0;                 // Released just after an edge
    end

endmodule
